// File: exec_unit.f
+incdir+verilog
verilog/exec_data_pkg.sv
verilog/exec_op_pkg.sv
verilog/cla_adder.sv
verilog/tree_comparator.sv
verilog/shift_right.sv
verilog/shift_left.sv
verilog/updown_counter.sv
verilog/exec_stage.sv
verilog/exec_unit.sv
test/exec_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build the exec_unit testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module exec_unit_tb -Mdir obj_dir -o exec_unit_sim \
	-f exec_unit.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/exec_unit_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
	exit 1
fi
exit 0

// File: test/exec_unit_tb.sv
`include "exec_settings.svh"

module exec_unit_tb import exec_data_pkg::*, exec_op_pkg::*; ();

	localparam int ops_per_phase = 400; // Cycles in each stimulus phase
	localparam int drive_delay = 5; // Inputs change this long after the rising edge
	localparam int drain_limit = 8; // Idle cycles allowed for the last result
	localparam logic [31:0] seed = 32'h9b6;

	logic clk;
	logic reset;
	logic op_valid;
	op_t op;
	word_t a;
	word_t b;
	logic carry_in;
	shift_mode_t shift_mode;
	shamt_t shamt;
	logic count;
	logic load;
	count_t load_value;
	word_t result;
	logic carry_out;
	logic above;
	logic below;
	logic result_valid;
	count_t count_value;
	logic will_overflow;

	logic [31:0] rng_state;
	int check_errors;
	int timeout_errors;
	logic [`WORD_WIDTH + 2:0] pending [$]; // {result, carry_out, above, below} in flight
	logic [`WORD_WIDTH + 2:0] held; // Last result, outputs hold it between pulses
	count_t model_count; // Counter value after the most recent edge

	exec_unit dut_i (
		.clk(clk),
		.reset(reset),
		.op_valid(op_valid),
		.op(op),
		.a(a),
		.b(b),
		.carry_in(carry_in),
		.shift_mode(shift_mode),
		.shamt(shamt),
		.count(count),
		.load(load),
		.load_value(load_value),
		.result(result),
		.carry_out(carry_out),
		.above(above),
		.below(below),
		.result_valid(result_valid),
		.count_value(count_value),
		.will_overflow(will_overflow)
	);

	always #20 clk = ~clk; // Period 40

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			check_errors++;
			$display("CHECK FAILED time=%0t signal=%s got=%h expected=%h",
				$time, name, actual, expected);
		end
	endtask

	// Reference result, packed as {result, carry_out, above, below}
	function automatic logic [`WORD_WIDTH + 2:0] expected_exec(input op_t o, input word_t x,
			input word_t y, input logic cin, input shift_mode_t m, input shamt_t s);
		logic [`WORD_WIDTH:0] wide;
		logic [31:0] pair; // Two words side by side, shifted as one
		word_t r;
		logic c;
		r = '0;
		c = 1'b0;
		case (o)
			OP_ADD: begin
				wide = {1'b0, x} + {1'b0, y} + {{`WORD_WIDTH{1'b0}}, cin};
				{c, r} = wide;
			end
			OP_SUB: begin
				wide = {1'b0, x} + {1'b0, ~y} + 17'd1; // Carry set means no borrow
				{c, r} = wide;
			end
			OP_SHR: begin
				case (m)
					SHIFT_LOGIC: r = x >> s;
					SHIFT_ARITH: r = word_t'($signed(x) >>> s);
					SHIFT_DOUBLE: begin
						pair = {y, x} >> s; // b bit 0 enters just above a
						r = pair[15:0];
					end
					default: begin
						pair = {x, x} >> s; // Rotate right
						r = pair[15:0];
					end
				endcase
			end
			OP_SHL: begin
				case (m)
					SHIFT_DOUBLE: begin
						pair = {x, y[14:0], 1'b0} << s; // Top of b[14:0] fills from below
						r = pair[31:16];
					end
					SHIFT_CYCLIC: begin
						pair = {x, x} << s;
						r = pair[31:16];
					end
					default: r = x << s; // Arithmetic same as logic
				endcase
			end
			default: r = '0; // Compare
		endcase
		return {r, c, x > y, x < y};
	endfunction

	// Phase 0 add/sub, 1 compare, 2 shifts, 3 mixed with gaps
	task automatic issue_op(input int phase);
		logic [31:0] r;
		logic [31:0] operands;
		r = next_random();
		operands = next_random();
		op_valid = 1'b1;
		case (phase)
			0: op = r[0] ? OP_SUB : OP_ADD;
			1: op = OP_CMP;
			2: op = r[0] ? OP_SHL : OP_SHR;
			default: begin
				op_valid = r[1] | r[2]; // Roughly one gap in four
				op = op_t'(r[5:3] % 3'd5);
			end
		endcase
		a = operands[15:0];
		b = operands[31:16];
		if (r[7:6] == 2'b00) b = a; // Equal operands now and then
		carry_in = r[8];
		shift_mode = shift_mode_t'(r[10:9]);
		shamt = r[14:11];
		if (r[16:15] == 2'b00) shamt = {4{r[17]}}; // Edge distances 0 and 15
	endtask

	task automatic drive_counter();
		logic [31:0] r;
		r = next_random();
		count = r[0] | r[1]; // Mostly counting
		load = r[2];
		case (r[5:3])
			3'd0: load_value = 8'h00; // Start near the wrap points
			3'd1: load_value = 8'hff;
			3'd2: load_value = 8'h01;
			3'd3: load_value = 8'hfe;
			default: load_value = r[15:8];
		endcase
	endtask

	// One clock: check what the last edge produced, then drive the next inputs
	task automatic run_cycle(input int phase);
		logic expected_overflow;
		@(posedge clk);
		#drive_delay;
		check_value("result_valid", result_valid, pending.size() != 0);
		if (result_valid === 1'b1 && pending.size() != 0) held = pending.pop_front();
		check_value("result", result, held[`WORD_WIDTH + 2:3]);
		check_value("carry_out", carry_out, held[2]);
		check_value("above", above, held[1]);
		check_value("below", below, held[0]);
		check_value("count_value", count_value, model_count);

		if (phase < 0) op_valid = 1'b0; // Idle
		else issue_op(phase);
		if (op_valid) pending.push_back(expected_exec(op, a, b, carry_in, shift_mode, shamt));

		drive_counter();
		expected_overflow = (count & load) ? (model_count == 8'h00) : (model_count == 8'hff);
		case ({count, load})
			2'b00: model_count = model_count; // Hold
			2'b01: model_count = load_value;
			2'b10: model_count = model_count + 8'd1;
			default: model_count = model_count - 8'd1;
		endcase
		#1;
		check_value("will_overflow", will_overflow, expected_overflow); // Before the edge
	endtask

	task automatic drain_results();
		int waited;
		waited = 0;
		while (pending.size() != 0 && waited < drain_limit) begin
			run_cycle(-1);
			waited++;
		end
		if (pending.size() != 0) begin
			timeout_errors++;
			$display("Timeout at %0t: result still outstanding after %0d idle cycles",
				$time, waited);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		op_valid = 1'b0;
		op = OP_ADD;
		a = '0;
		b = '0;
		carry_in = 1'b0;
		shift_mode = SHIFT_LOGIC;
		shamt = '0;
		count = 1'b0;
		load = 1'b0;
		load_value = '0;
		rng_state = seed;
		check_errors = 0;
		timeout_errors = 0;
		held = '0;
		model_count = '0;

		repeat (16) @(posedge clk);
		#drive_delay;
		reset = 1'b0;
		#1;
		// Reset values, nothing driven yet
		check_value("result_valid", result_valid, 1'b0);
		check_value("result", result, '0);
		check_value("carry_out", carry_out, 1'b0);
		check_value("above", above, 1'b0);
		check_value("below", below, 1'b0);
		check_value("count_value", count_value, '0);

		for (int phase = 0; phase < 4; phase++) begin
			repeat (ops_per_phase) run_cycle(phase);
		end
		drain_results();
		repeat (4) run_cycle(-1); // No stray pulses once idle

		$display("Errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/cla_adder.sv
module cla_adder #(
	parameter int width = 16
) (
	input logic carry_in,
	input logic [width - 1:0] a,
	input logic [width - 1:0] b,
	output logic [width - 1:0] sum,
	output logic group_propagate,
	output logic group_generate,
	output logic carry_out
);

	logic [width - 1:0] p; // Per-bit propagate
	logic [width - 1:0] g; // Per-bit generate
	logic [width - 1:0] c; // Carry into each bit
	logic [width:0] gen_chain; // Carry at bit i with carry in held at zero
	logic [width:0] prop_chain; // All propagates below bit i

	assign p = a | b;
	assign g = a & b;

	// Lookahead terms, flattened by synthesis
	always_comb begin
		gen_chain[0] = 1'b0;
		prop_chain[0] = 1'b1;
		for (int i = 0; i < width; i++) begin
			gen_chain[i + 1] = g[i] | (p[i] & gen_chain[i]);
			prop_chain[i + 1] = prop_chain[i] & p[i];
		end
	end

	// Carry in only reaches bit i through an unbroken propagate run
	assign c = gen_chain[width - 1:0] | (prop_chain[width - 1:0] & {width{carry_in}});

	assign sum = (p & ~g) ^ c; // Half-sum is p and not g
	assign carry_out = gen_chain[width] | (prop_chain[width] & carry_in);

	// Group terms for a higher lookahead level
	assign group_propagate = prop_chain[width];
	assign group_generate = gen_chain[width];

	// Lookahead chain against plain arithmetic
	always_comb begin
		assert final ({carry_out, sum} ==
				{1'b0, a} + {1'b0, b} + {{width{1'b0}}, carry_in})
			else $error("cla_adder sum mismatch");
	end

endmodule

// File: verilog/exec_data_pkg.sv
`include "exec_settings.svh"

package exec_data_pkg;

	typedef logic [`WORD_WIDTH - 1:0] word_t; // Operand or result word

	// Bits shifted in for double-precision and cyclic shifts
	typedef logic [`WORD_WIDTH - 2:0] fill_t;

	typedef logic [`SHAMT_WIDTH - 1:0] shamt_t; // Shift distance

	typedef logic [`COUNT_WIDTH - 1:0] count_t; // Counter value

endpackage

// File: verilog/exec_op_pkg.sv
package exec_op_pkg;

	// Operations of the execute stage
	typedef enum logic [2:0] {
		OP_ADD, // a + b + carry_in
		OP_SUB, // a - b, carry out means no borrow
		OP_CMP, // Flags only
		OP_SHR,
		OP_SHL
	} op_t;

	// Fill source for the bits vacated by a shift
	typedef enum logic [1:0] {SHIFT_LOGIC, SHIFT_ARITH, SHIFT_DOUBLE, SHIFT_CYCLIC} shift_mode_t;

endpackage

// File: verilog/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Operand and result width
`define WORD_WIDTH 16

// Shift amount width, log2 of the word width
`define SHAMT_WIDTH 4

// Counter width
`define COUNT_WIDTH 8

`endif

// File: verilog/exec_stage.sv
`include "exec_settings.svh"

module exec_stage import exec_data_pkg::*, exec_op_pkg::*; (
	input logic clk,
	input logic reset,
	input logic op_valid,
	input op_t op,
	input word_t a,
	input word_t b,
	input logic carry_in,
	input shift_mode_t shift_mode,
	input shamt_t shamt,
	output word_t result,
	output logic carry_out,
	output logic above,
	output logic below,
	output logic result_valid // Pulses the cycle after op_valid
);

	word_t adder_b;
	logic adder_carry_in;
	word_t sum;
	logic sum_carry;
	logic cmp_above;
	logic cmp_below;
	word_t shr_out;
	word_t shl_out;
	word_t result_next;
	logic carry_next;

	// Subtract is a plus inverted b plus one
	assign adder_b = (op == OP_SUB) ? ~b : b;
	assign adder_carry_in = (op == OP_SUB) ? 1'b1 : carry_in;

	cla_adder #(.width(`WORD_WIDTH)) adder_i (
		.carry_in(adder_carry_in),
		.a(a),
		.b(adder_b),
		.sum(sum),
		.group_propagate(), // Single level, no upper lookahead
		.group_generate(),
		.carry_out(sum_carry) // No borrow on subtract
	);

	tree_comparator #(.width(`WORD_WIDTH)) comparator_i (
		.a(a),
		.b(b),
		.above(cmp_above),
		.below(cmp_below)
	);

	// b low bits feed double-precision fill in both directions
	shift_right shift_right_i (
		.data(a),
		.fill(b[`WORD_WIDTH - 2:0]),
		.shamt(shamt),
		.mode(shift_mode),
		.shifted(shr_out)
	);

	shift_left shift_left_i (
		.data(a),
		.fill(b[`WORD_WIDTH - 2:0]),
		.shamt(shamt),
		.mode(shift_mode),
		.shifted(shl_out)
	);

	always_comb begin
		carry_next = 1'b0; // Only add and subtract report a carry
		case (op)
			OP_ADD, OP_SUB: begin
				result_next = sum;
				carry_next = sum_carry;
			end
			OP_SHR: result_next = shr_out;
			OP_SHL: result_next = shl_out;
			default: result_next = '0; // Compare gives flags only
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			result_valid <= 1'b0;
			result <= '0;
			carry_out <= 1'b0;
			above <= 1'b0;
			below <= 1'b0;
		end else begin
			result_valid <= op_valid;
			if (op_valid) begin // Outputs hold between operations
				result <= result_next;
				carry_out <= carry_next;
				above <= cmp_above; // Flags on every operation
				below <= cmp_below;
			end
		end
	end

	// Every strobe gives exactly one result pulse, one cycle on
	assert property (@(posedge clk) disable iff (reset) op_valid |=> result_valid);
	assert property (@(posedge clk) disable iff (reset) result_valid |-> $past(op_valid));

endmodule

// File: verilog/exec_unit.sv
module exec_unit import exec_data_pkg::*, exec_op_pkg::*; (
	input logic clk,
	input logic reset,
	// Operation, sampled with op_valid
	input logic op_valid,
	input op_t op,
	input word_t a,
	input word_t b,
	input logic carry_in,
	input shift_mode_t shift_mode,
	input shamt_t shamt,
	// Counter controls, sampled every cycle
	input logic count,
	input logic load,
	input count_t load_value,
	// Registered execute results
	output word_t result,
	output logic carry_out,
	output logic above,
	output logic below,
	output logic result_valid,
	// Counter state
	output count_t count_value,
	output logic will_overflow
);

	exec_stage exec_stage_i (
		.clk(clk),
		.reset(reset),
		.op_valid(op_valid),
		.op(op),
		.a(a),
		.b(b),
		.carry_in(carry_in),
		.shift_mode(shift_mode),
		.shamt(shamt),
		.result(result),
		.carry_out(carry_out),
		.above(above),
		.below(below),
		.result_valid(result_valid)
	);

	// Runs independently of the execute stage
	updown_counter counter_i (
		.clk(clk),
		.reset(reset),
		.count(count),
		.load(load),
		.load_value(load_value),
		.value(count_value),
		.will_overflow(will_overflow)
	);

endmodule

// File: verilog/shift_left.sv
`include "exec_settings.svh"

module shift_left import exec_data_pkg::*, exec_op_pkg::*; (
	input word_t data,
	input fill_t fill, // Bits entering from the bottom in double mode
	input shamt_t shamt,
	input shift_mode_t mode,
	output word_t shifted
);

	fill_t fill_bits; // Source of the vacated low bits, taken from the top down
	word_t stage [`WORD_WIDTH];

	always_comb begin
		case (mode)
			SHIFT_DOUBLE: fill_bits = fill;
			SHIFT_CYCLIC: fill_bits = data[`WORD_WIDTH - 1:1]; // High bits wrap round
			default: fill_bits = '0; // Logic and arithmetic alike
		endcase
	end

	assign stage[0] = data;

	genvar i;
	generate
		for (i = 1; i < `WORD_WIDTH; i++) begin : distance
			// Senior fill bits enter first
			assign stage[i] = {data[`WORD_WIDTH - 1 - i:0], fill_bits[`WORD_WIDTH - 2 -: i]};
		end
	endgenerate

	// One stage per distance, picked by shamt
	assign shifted = stage[shamt];

endmodule

// File: verilog/shift_right.sv
`include "exec_settings.svh"

module shift_right import exec_data_pkg::*, exec_op_pkg::*; (
	input word_t data,
	input fill_t fill, // Bits entering from the top in double mode
	input shamt_t shamt,
	input shift_mode_t mode,
	output word_t shifted
);

	fill_t fill_bits; // Source of the vacated high bits
	word_t stage [`WORD_WIDTH]; // Every shift distance

	always_comb begin
		case (mode)
			SHIFT_ARITH: fill_bits = {(`WORD_WIDTH - 1){data[`WORD_WIDTH - 1]}}; // Sign copies
			SHIFT_DOUBLE: fill_bits = fill;
			SHIFT_CYCLIC: fill_bits = data[`WORD_WIDTH - 2:0]; // Low bits wrap round
			default: fill_bits = '0; // Logic
		endcase
	end

	assign stage[0] = data;

	genvar i;
	generate
		for (i = 1; i < `WORD_WIDTH; i++) begin : distance
			// Fill bit 0 lands just above the remaining data bits
			assign stage[i] = {fill_bits[i - 1:0], data[`WORD_WIDTH - 1:i]};
		end
	endgenerate

	assign shifted = stage[shamt];

endmodule

// File: verilog/tree_comparator.sv
module tree_comparator #(
	parameter int width = 16
) (
	input logic [width - 1:0] a,
	input logic [width - 1:0] b,
	output logic above, // a > b unsigned
	output logic below // a < b unsigned
);

	// Equal is neither above nor below
	localparam int levels = $clog2(width);

	// Level 0 holds per-bit terms, each level up halves the node count
	logic [levels:0][width - 1:0] above_tree;
	logic [levels:0][width - 1:0] below_tree;

	assign above_tree[0] = a & ~b;
	assign below_tree[0] = ~a & b;

	genvar l, k;
	generate
		for (l = 1; l <= levels; l++) begin : level
			localparam int prev_nodes = (width + (1 << (l - 1)) - 1) >> (l - 1);
			localparam int nodes = (width + (1 << l) - 1) >> l;
			for (k = 0; k < nodes; k++) begin : node
				if (2 * k + 1 < prev_nodes) begin : merge
					// Senior half decides unless it is equal
					assign above_tree[l][k] = above_tree[l - 1][2 * k + 1] |
						(~below_tree[l - 1][2 * k + 1] & above_tree[l - 1][2 * k]);
					assign below_tree[l][k] = below_tree[l - 1][2 * k + 1] |
						(~above_tree[l - 1][2 * k + 1] & below_tree[l - 1][2 * k]);
				end else begin : pass
					// Odd senior node has no partner at this level
					assign above_tree[l][k] = above_tree[l - 1][2 * k];
					assign below_tree[l][k] = below_tree[l - 1][2 * k];
				end
			end
			if (nodes < width) begin : unused_nodes
				assign above_tree[l][width - 1:nodes] = '0;
				assign below_tree[l][width - 1:nodes] = '0;
			end
		end
	endgenerate

	assign above = above_tree[levels][0]; // Root of the tree
	assign below = below_tree[levels][0];

	// Flags are exclusive
	always_comb begin
		assert final (!(above && below))
			else $error("tree_comparator above and below both set");
	end

endmodule

// File: verilog/updown_counter.sv
`include "exec_settings.svh"

module updown_counter import exec_data_pkg::*; (
	input logic clk,
	input logic reset,
	input logic count,
	input logic load, // With count set, selects counting down
	input count_t load_value,
	output count_t value,
	output logic will_overflow // Next count wraps
);

	logic down;
	logic [`COUNT_WIDTH:0] borrow; // Bit i toggles on a borrow from below
	logic [`COUNT_WIDTH:0] carry; // Bit i toggles on a carry from below
	count_t next_value;

	assign down = count & load;

	always_comb begin
		borrow[0] = 1'b1;
		carry[0] = 1'b1;
		for (int i = 0; i < `COUNT_WIDTH; i++) begin
			borrow[i + 1] = borrow[i] & ~value[i];
			carry[i + 1] = carry[i] & value[i];
		end
	end

	assign next_value = value ^ (down ? borrow[`COUNT_WIDTH - 1:0] : carry[`COUNT_WIDTH - 1:0]);
	assign will_overflow = down ? borrow[`COUNT_WIDTH] : carry[`COUNT_WIDTH]; // Chain end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			value <= '0;
		end else if (count) begin
			value <= next_value; // Up or down
		end else if (load) begin
			value <= load_value;
		end
	end

	// A flagged count wraps to zero going up, to all ones going down
	assert property (@(posedge clk) disable iff (reset)
		count && will_overflow |=> value == {`COUNT_WIDTH{$past(load)}});

endmodule
